// ==== common/drbg_pkg.sv ====
package drbg_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int data_w     = 32;
    localparam int addr_w     = 6;
    // apb word index, byte address without the two low bits
    localparam int word_w     = addr_w - 2;
    localparam int ram_addr_w = 3;
    // mixer rounds applied to each candidate
    localparam int mix_rounds = 4;

    // register word map
    localparam logic [word_w-1:0] reg_ctrl        = 4'd0;
    localparam logic [word_w-1:0] reg_status      = 4'd1;
    localparam logic [word_w-1:0] reg_seed        = 4'd2;
    localparam logic [word_w-1:0] reg_iv          = 4'd3;
    localparam logic [word_w-1:0] reg_privkey     = 4'd4;
    localparam logic [word_w-1:0] reg_hashed_msg  = 4'd5;
    localparam logic [word_w-1:0] reg_lambda      = 4'd6;
    localparam logic [word_w-1:0] reg_scalar_rnd  = 4'd7;
    localparam logic [word_w-1:0] reg_masking_rnd = 4'd8;
    localparam logic [word_w-1:0] reg_nonce       = 4'd9;

    // operand ram slots, word 2 lands in slot 0
    localparam logic [ram_addr_w-1:0] slot_seed        = 3'd0;
    localparam logic [ram_addr_w-1:0] slot_iv          = 3'd1;
    localparam logic [ram_addr_w-1:0] slot_privkey     = 3'd2;
    localparam logic [ram_addr_w-1:0] slot_hashed_msg  = 3'd3;
    localparam logic [ram_addr_w-1:0] slot_lambda      = 3'd4;
    localparam logic [ram_addr_w-1:0] slot_scalar_rnd  = 3'd5;
    localparam logic [ram_addr_w-1:0] slot_masking_rnd = 3'd6;
    localparam logic [ram_addr_w-1:0] slot_nonce       = 3'd7;

    // ------------------------------------------------------------------------
    // bus structs
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [addr_w-1:0] paddr;
        logic [data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [ram_addr_w-1:0] addr;
        logic [data_w-1:0]     wdata;
    } ram_req_t;

    // grant in the request cycle, rvalid one cycle after a granted read
    typedef struct packed {
        logic              grant;
        logic              rvalid;
        logic [data_w-1:0] rdata;
    } ram_rsp_t;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_INIT,
        CMD_NEXT
    } drbg_cmd_e;

    typedef enum logic [3:0] {
        IDLE,
        FETCH,
        LAMBDA,
        SCALAR_RND,
        RND_DONE,
        MASKING_RND,
        KEYGEN,
        SIGN,
        STORE,
        DONE
    } seq_state_e;

endpackage

// ==== design/apb_host_port.sv ====
`timescale 1ns/1ps

module apb_host_port (
    input  logic               clk,
    input  logic               reset_n,
    input  drbg_pkg::apb_req_t apb_req,
    output drbg_pkg::apb_rsp_t apb_rsp,
    output drbg_pkg::ram_req_t ram_req,
    input  drbg_pkg::ram_rsp_t ram_rsp,
    output logic               start,
    output logic               keygen_sign,
    input  logic               seq_ready,
    input  logic               seq_done
);
    import drbg_pkg::*;

    logic [word_w-1:0] word;
    logic              access;
    logic              is_reg;
    logic              is_oper;
    logic              is_result;
    logic              err;
    logic              ram_go;
    // read granted, waiting on rvalid
    logic              wait_rsp;
    // ram access finishes this cycle
    logic              fin;
    logic              busy;
    logic              done_bit;
    logic [data_w-1:0] rdata_q;
    logic [data_w-1:0] reg_rdata;

    // ------------------------------------------------------------------------
    // address decode and error rules
    // ------------------------------------------------------------------------
    assign word      = apb_req.paddr[addr_w-1:2];
    assign access    = apb_req.psel && apb_req.penable;
    assign is_reg    = (word <= reg_status);
    assign is_oper   = (word >= reg_seed) && (word <= reg_hashed_msg);
    assign is_result = (word >= reg_lambda) && (word <= reg_nonce);

    // results and status are read only, operands locked while a run is busy
    assign err = (word > reg_nonce)
              || (apb_req.pwrite && (word == reg_status || is_result))
              || (apb_req.pwrite && is_oper && !seq_ready);

    assign busy   = wait_rsp || fin;
    assign ram_go = access && (is_oper || is_result) && !err && !busy;

    // held by the apb access phase until the arbiter grants
    always_comb
    begin
        ram_req.valid = ram_go;
        ram_req.write = apb_req.pwrite;
        ram_req.addr  = ram_addr_w'(word - reg_seed);
        ram_req.wdata = apb_req.pwdata;
    end

    always_comb
    begin
        reg_rdata = '0;
        if (word == reg_ctrl)
            reg_rdata[1] = keygen_sign;
        else if (word == reg_status)
            reg_rdata[1:0] = {done_bit, seq_ready};
    end

    // register and error accesses end in the first access cycle
    assign apb_rsp.pready  = access && (fin || (!busy && (is_reg || err)));
    assign apb_rsp.pslverr = access && !busy && err;
    assign apb_rsp.prdata  = fin ? rdata_q : reg_rdata;

    // ------------------------------------------------------------------------
    // handshake and control registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            wait_rsp    <= 1'b0;
            fin         <= 1'b0;
            start       <= 1'b0;
            keygen_sign <= 1'b0;
            done_bit    <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            fin   <= 1'b0;
            if (ram_go && ram_rsp.grant)
            begin
                // a write is done once granted, a read waits for its data
                if (apb_req.pwrite)
                    fin <= 1'b1;
                else
                    wait_rsp <= 1'b1;
            end
            if (wait_rsp && ram_rsp.rvalid)
            begin
                wait_rsp <= 1'b0;
                fin      <= 1'b1;
            end
            if (access && !busy && apb_req.pwrite && word == reg_ctrl)
            begin
                start       <= apb_req.pwdata[0];
                keygen_sign <= apb_req.pwdata[1];
                if (apb_req.pwdata[0])
                    done_bit <= 1'b0;
            end
            // sticky until the next start
            if (seq_done)
                done_bit <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wait_rsp && ram_rsp.rvalid)
            rdata_q <= ram_rsp.rdata;
    end

endmodule

// ==== design/ecc_drbg_top.sv ====
`timescale 1ns/1ps

module ecc_drbg_top #(
    parameter logic [drbg_pkg::data_w-1:0] GROUP_ORDER = 32'hFFFFFFC5
) (
    input  logic               clk,
    input  logic               reset_n,
    input  drbg_pkg::apb_req_t apb_req,
    output drbg_pkg::apb_rsp_t apb_rsp
);
    import drbg_pkg::*;

    // two requesters share the operand ram
    ram_req_t          host_ram_req;
    ram_rsp_t          host_ram_rsp;
    ram_req_t          seq_ram_req;
    ram_rsp_t          seq_ram_rsp;
    ram_req_t          ram_req;
    logic [data_w-1:0] ram_rdata;
    logic              ram_rvalid;
    logic              seq_start;
    logic              seq_keygen_sign;
    logic              seq_ready;
    logic              seq_done;

    apb_host_port u_host (
        .clk        (clk),
        .reset_n    (reset_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .ram_req    (host_ram_req),
        .ram_rsp    (host_ram_rsp),
        .start      (seq_start),
        .keygen_sign(seq_keygen_sign),
        .seq_ready  (seq_ready),
        .seq_done   (seq_done)
    );

    ram_arbiter u_arb (
        .clk       (clk),
        .reset_n   (reset_n),
        .host_req  (host_ram_req),
        .host_rsp  (host_ram_rsp),
        .seq_req   (seq_ram_req),
        .seq_rsp   (seq_ram_rsp),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata),
        .ram_rvalid(ram_rvalid)
    );

    operand_ram u_ram (
        .clk    (clk),
        .reset_n(reset_n),
        .req    (ram_req),
        .rdata  (ram_rdata),
        .rvalid (ram_rvalid)
    );

    drbg_sequencer #(
        .GROUP_ORDER(GROUP_ORDER)
    ) u_seq (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (seq_start),
        .keygen_sign(seq_keygen_sign),
        .ready      (seq_ready),
        .done       (seq_done),
        .ram_req    (seq_ram_req),
        .ram_rsp    (seq_ram_rsp)
    );

endmodule

// ==== design/operand_ram.sv ====
`timescale 1ns/1ps

module operand_ram (
    input  logic                        clk,
    input  logic                        reset_n,
    input  drbg_pkg::ram_req_t          req,
    output logic [drbg_pkg::data_w-1:0] rdata,
    output logic                        rvalid
);
    import drbg_pkg::*;

    // four operand words followed by four result words
    logic [data_w-1:0] mem [2**ram_addr_w];

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < 2**ram_addr_w; i++)
                mem[i] <= '0;
            rdata  <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            // read data shows up one cycle after the request
            rvalid <= req.valid && !req.write;
            if (req.valid && !req.write)
                rdata <= mem[req.addr];
            if (req.valid && req.write)
                mem[req.addr] <= req.wdata;
        end
    end

endmodule

// ==== design/ram_arbiter.sv ====
`timescale 1ns/1ps

module ram_arbiter (
    input  logic                        clk,
    input  logic                        reset_n,
    input  drbg_pkg::ram_req_t          host_req,
    output drbg_pkg::ram_rsp_t          host_rsp,
    input  drbg_pkg::ram_req_t          seq_req,
    output drbg_pkg::ram_rsp_t          seq_rsp,
    output drbg_pkg::ram_req_t          ram_req,
    input  logic [drbg_pkg::data_w-1:0] ram_rdata,
    input  logic                        ram_rvalid
);

    // last winner was the host port, so the sequencer goes first on contention
    logic host_last;
    logic grant_host;
    logic grant_seq;
    // owner of the read that is in flight
    logic rd_host;

    // ------------------------------------------------------------------------
    // round robin choice
    // ------------------------------------------------------------------------
    assign grant_seq  = seq_req.valid && (!host_req.valid || host_last);
    assign grant_host = host_req.valid && !grant_seq;

    always_comb
    begin
        ram_req       = grant_host ? host_req : seq_req;
        ram_req.valid = grant_host || grant_seq;
    end

    // read data only goes back to the requester that owns the read
    always_comb
    begin
        host_rsp.grant  = grant_host;
        host_rsp.rvalid = ram_rvalid && rd_host;
        host_rsp.rdata  = rd_host ? ram_rdata : '0;
        seq_rsp.grant   = grant_seq;
        seq_rsp.rvalid  = ram_rvalid && !rd_host;
        seq_rsp.rdata   = rd_host ? '0 : ram_rdata;
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            host_last <= 1'b1;
            rd_host   <= 1'b0;
        end
        else
        begin
            if (grant_host || grant_seq)
                host_last <= grant_host;
            // note who gets the rvalid next cycle
            if (ram_req.valid && !ram_req.write)
                rd_host <= grant_host;
        end
    end

endmodule

// ==== drbg/drbg_core.sv ====
`timescale 1ns/1ps

module drbg_core #(
    parameter logic [drbg_pkg::data_w-1:0] GROUP_ORDER = 32'hFFFFFFC5
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  drbg_pkg::drbg_cmd_e         cmd,
    input  logic [drbg_pkg::data_w-1:0] seed,
    output logic                        ready,
    output logic                        valid,
    output logic [drbg_pkg::data_w-1:0] value
);
    import drbg_pkg::*;

    localparam int rnd_w = $clog2(mix_rounds);

    // key, counter and running mixer state
    logic [data_w-1:0] key;
    logic [data_w-1:0] ctr;
    logic [data_w-1:0] x;
    logic [data_w-1:0] x_mix;
    logic [rnd_w-1:0]  rnd;
    logic              busy;
    logic              last_round;
    logic              accept;

    // one round, rotate left by 7 xor the keyed sum
    function automatic logic [data_w-1:0] mix_round(
        input logic [data_w-1:0] v,
        input logic [data_w-1:0] k
    );
        return {v[data_w-8:0], v[data_w-1:data_w-7]} ^ (v + k);
    endfunction

    assign x_mix      = mix_round(x, key);
    assign last_round = (rnd == rnd_w'(mix_rounds - 1));
    // candidate must lie in [1, GROUP_ORDER)
    assign accept     = (x_mix != '0) && (x_mix < GROUP_ORDER);
    assign ready      = !busy;
    assign value      = x;

    // ------------------------------------------------------------------------
    // command and round sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            key   <= '0;
            ctr   <= '0;
            x     <= '0;
            rnd   <= '0;
            busy  <= 1'b0;
            valid <= 1'b0;
        end
        else if (ready && cmd != CMD_NONE)
        begin
            // valid drops on every new command
            busy  <= 1'b1;
            valid <= 1'b0;
            rnd   <= '0;
            if (cmd == CMD_INIT)
            begin
                key <= seed;
                ctr <= '0;
                // counter is zero so the start value is the seed itself
                x   <= seed;
            end
            else
            begin
                ctr <= ctr + 1'b1;
                x   <= key ^ (ctr + 1'b1);
            end
        end
        else if (busy)
        begin
            x   <= x_mix;
            rnd <= last_round ? '0 : rnd + 1'b1;
            // rejected candidates just run another block of rounds
            if (last_round && accept)
            begin
                busy  <= 1'b0;
                valid <= 1'b1;
            end
        end
    end

endmodule

// ==== drbg/drbg_sequencer.sv ====
`timescale 1ns/1ps

module drbg_sequencer #(
    parameter logic [drbg_pkg::data_w-1:0] GROUP_ORDER = 32'hFFFFFFC5
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               start,
    input  logic               keygen_sign,
    output logic               ready,
    output logic               done,
    output drbg_pkg::ram_req_t ram_req,
    input  drbg_pkg::ram_rsp_t ram_rsp
);
    import drbg_pkg::*;

    seq_state_e            state;
    seq_state_e            state_next;
    seq_state_e            state_last;
    // generate state whose value is being stored
    seq_state_e            step;
    logic                  mode_q;
    logic                  first_round;
    logic [1:0]            fetch_idx;
    logic                  rd_pending;
    logic [ram_addr_w-1:0] fetch_slot;
    logic [ram_addr_w-1:0] store_slot;
    logic [data_w-1:0]     iv_q;
    logic [data_w-1:0]     seed_q;
    logic [data_w-1:0]     privkey_q;
    logic [data_w-1:0]     hashed_q;
    drbg_cmd_e             core_cmd;
    logic [data_w-1:0]     core_seed;
    logic [data_w-1:0]     core_value;
    logic                  core_ready;
    logic                  core_valid;
    logic                  valid_last;
    logic                  valid_edge;

    drbg_core #(
        .GROUP_ORDER(GROUP_ORDER)
    ) u_core (
        .clk    (clk),
        .reset_n(reset_n),
        .cmd    (core_cmd),
        .seed   (core_seed),
        .ready  (core_ready),
        .valid  (core_valid),
        .value  (core_value)
    );

    // ------------------------------------------------------------------------
    // core command and seed
    // ------------------------------------------------------------------------
    assign first_round = (state != state_last);
    assign valid_edge  = core_valid && !valid_last;

    always_comb
    begin
        core_cmd  = CMD_NONE;
        core_seed = '0;
        case (state)
            LAMBDA, SCALAR_RND, MASKING_RND: core_seed = iv_q;
            KEYGEN:                          core_seed = seed_q;
            SIGN:                            core_seed = privkey_q ^ hashed_q;
            default:                         core_seed = '0;
        endcase
        // one command on entry to each generate state
        if (first_round)
        begin
            case (state)
                LAMBDA, KEYGEN, SIGN:    core_cmd = CMD_INIT;
                SCALAR_RND, MASKING_RND: core_cmd = CMD_NEXT;
                default:                 core_cmd = CMD_NONE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // ram traffic
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (fetch_idx)
            2'd0:    fetch_slot = slot_iv;
            2'd1:    fetch_slot = slot_seed;
            2'd2:    fetch_slot = slot_privkey;
            default: fetch_slot = slot_hashed_msg;
        endcase
        case (step)
            LAMBDA:      store_slot = slot_lambda;
            SCALAR_RND:  store_slot = slot_scalar_rnd;
            MASKING_RND: store_slot = slot_masking_rnd;
            default:     store_slot = slot_nonce;
        endcase
    end

    always_comb
    begin
        ram_req = '0;
        if (state == FETCH && !rd_pending)
        begin
            ram_req.valid = 1'b1;
            ram_req.addr  = fetch_slot;
        end
        else if (state == STORE)
        begin
            // core holds its value until the next command
            ram_req.valid = 1'b1;
            ram_req.write = 1'b1;
            ram_req.addr  = store_slot;
            ram_req.wdata = core_value;
        end
    end

    // ------------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------------
    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (start && core_ready)
                    state_next = FETCH;
            FETCH:
                if (rd_pending && ram_rsp.rvalid && fetch_idx == 2'd3)
                    state_next = LAMBDA;
            LAMBDA, SCALAR_RND, MASKING_RND, KEYGEN, SIGN:
                if (valid_edge)
                    state_next = STORE;
            RND_DONE:
                state_next = mode_q ? MASKING_RND : KEYGEN;
            STORE:
                if (ram_rsp.grant)
                begin
                    case (step)
                        LAMBDA:      state_next = SCALAR_RND;
                        SCALAR_RND:  state_next = RND_DONE;
                        MASKING_RND: state_next = SIGN;
                        default:     state_next = DONE;
                    endcase
                end
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state      <= IDLE;
            state_last <= IDLE;
            step       <= IDLE;
            valid_last <= 1'b0;
            mode_q     <= 1'b0;
            fetch_idx  <= '0;
            rd_pending <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            state_last <= state;
            valid_last <= core_valid;
            if (state == IDLE && state_next == FETCH)
                mode_q <= keygen_sign;
            if (valid_edge)
                step <= state;
            if (state == FETCH)
            begin
                if (!rd_pending && ram_rsp.grant)
                    rd_pending <= 1'b1;
                // index wraps back to zero after the last operand
                if (rd_pending && ram_rsp.rvalid)
                begin
                    rd_pending <= 1'b0;
                    fetch_idx  <= fetch_idx + 1'b1;
                end
            end
        end
    end

    // operand copies for the whole run
    always_ff @(posedge clk)
    begin
        if (state == FETCH && rd_pending && ram_rsp.rvalid)
        begin
            case (fetch_idx)
                2'd0:    iv_q      <= ram_rsp.rdata;
                2'd1:    seed_q    <= ram_rsp.rdata;
                2'd2:    privkey_q <= ram_rsp.rdata;
                default: hashed_q  <= ram_rsp.rdata;
            endcase
        end
    end

    assign ready = (state == IDLE);
    assign done  = (state == DONE);

endmodule

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module drbg_tb -f verilog.f -o drbg_sim
./obj_dir/drbg_sim

// ==== verification/drbg_assertions.sv ====
`timescale 1ns/1ps

module drbg_assertions (
    input logic                clk,
    input logic                reset_n,
    input drbg_pkg::apb_req_t  apb_req,
    input drbg_pkg::apb_rsp_t  apb_rsp,
    input drbg_pkg::ram_req_t  host_req,
    input drbg_pkg::ram_rsp_t  host_rsp,
    input drbg_pkg::ram_req_t  seq_req,
    input drbg_pkg::ram_rsp_t  seq_rsp,
    input drbg_pkg::drbg_cmd_e core_cmd,
    input logic                core_ready,
    input logic                core_valid
);
    import drbg_pkg::*;

    // access cycles seen so far without pready
    logic [3:0] wait_cycles;
    // a command was taken and its value has not shown up yet
    logic       cmd_pending;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            wait_cycles <= '0;
            cmd_pending <= 1'b0;
        end
        else
        begin
            if (apb_req.psel && apb_req.penable && !apb_rsp.pready)
                wait_cycles <= wait_cycles + 1'b1;
            else
                wait_cycles <= '0;
            if (core_ready && core_cmd != CMD_NONE)
                cmd_pending <= 1'b1;
            else if (core_valid)
                cmd_pending <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // bus and handshake rules
    // ------------------------------------------------------------------------
    one_grant: assert property (@(posedge clk) disable iff (!reset_n)
        !(host_rsp.grant && seq_rsp.grant))
    else
        $error("arbiter granted both requesters");

    pready_bound: assert property (@(posedge clk) disable iff (!reset_n)
        (apb_req.psel && apb_req.penable) |-> (wait_cycles < 4'd8))
    else
        $error("pready missing for more than 8 access cycles");

    valid_after_cmd: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(core_valid) |-> cmd_pending)
    else
        $error("core valid rose without a command");

    host_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (host_req.valid && !host_rsp.grant) |=> $stable(host_req))
    else
        $error("host ram request changed before grant");

    seq_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (seq_req.valid && !seq_rsp.grant) |=> $stable(seq_req))
    else
        $error("sequencer ram request changed before grant");

endmodule

bind ecc_drbg_top drbg_assertions u_assertions (
    .clk       (clk),
    .reset_n   (reset_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .host_req  (host_ram_req),
    .host_rsp  (host_ram_rsp),
    .seq_req   (seq_ram_req),
    .seq_rsp   (seq_ram_rsp),
    .core_cmd  (u_seq.core_cmd),
    .core_ready(u_seq.core_ready),
    .core_valid(u_seq.core_valid)
);

// ==== verification/drbg_tb.sv ====
`timescale 1ns/1ps

module drbg_tb;
    import drbg_pkg::*;

    localparam int                ACCESS_TIMEOUT = 16;
    localparam int                RUN_TIMEOUT    = 400;
    localparam logic [data_w-1:0] GROUP_ORDER    = 32'hFFFFFFC5;

    logic              clk;
    logic              reset_n;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;
    // expected contents of the eight ram slots with operands first
    logic [data_w-1:0] exp_mem [8];
    integer            seed;

    ecc_drbg_top dut (
        .clk    (clk),
        .reset_n(reset_n),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------------------
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
            stop_with_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    function automatic string word_name(input int w);
        case (w)
            2:       return "seed";
            3:       return "iv";
            4:       return "privkey";
            5:       return "hashed_msg";
            6:       return "lambda";
            7:       return "scalar_rnd";
            8:       return "masking_rnd";
            default: return "nonce";
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // reference model of the mixer and the seed table
    // ------------------------------------------------------------------------
    function automatic logic [31:0] gen_value(input logic [31:0] key, input logic [31:0] ctr);
        logic [31:0] x;
        logic        accepted;
        x        = key ^ ctr;
        accepted = 1'b0;
        // blocks of four rounds until the candidate lies in [1, order)
        while (!accepted)
        begin
            for (int r = 0; r < mix_rounds; r++)
                x = {x[24:0], x[31:25]} ^ (x + key);
            accepted = (x != 32'h0) && (x < GROUP_ORDER);
        end
        return x;
    endfunction

    task automatic run_model(input logic sign);
        exp_mem[slot_lambda]     = gen_value(exp_mem[slot_iv], 32'd0);
        exp_mem[slot_scalar_rnd] = gen_value(exp_mem[slot_iv], 32'd1);
        if (sign)
        begin
            exp_mem[slot_masking_rnd] = gen_value(exp_mem[slot_iv], 32'd2);
            exp_mem[slot_nonce] =
                gen_value(exp_mem[slot_privkey] ^ exp_mem[slot_hashed_msg], 32'd0);
        end
        else
            exp_mem[slot_nonce] = gen_value(exp_mem[slot_seed], 32'd0);
    endtask

    // ------------------------------------------------------------------------
    // apb master drives on the falling edge and samples on the rising edge
    // ------------------------------------------------------------------------
    task automatic apb_access(input logic write, input logic [3:0] word, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        int   cycles;
        logic finished;
        cycles   = 0;
        finished = 1'b0;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = {word, 2'b00};
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        while (!finished)
        begin
            @(posedge clk);
            if (apb_rsp.pready)
            begin
                rdata    = apb_rsp.prdata;
                slverr   = apb_rsp.pslverr;
                finished = 1'b1;
            end
            else
            begin
                cycles++;
                if (cycles > ACCESS_TIMEOUT)
                    stop_with_error($sformatf("timeout: no pready on word %0d", word));
            end
        end
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] word, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, word, data, unused, err);
    endtask

    task automatic apb_read(input logic [3:0] word, output logic [31:0] data, output logic err);
        apb_access(1'b0, word, 32'h0, data, err);
    endtask

    task automatic read_expect(input string name, input logic [3:0] word, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(word, data, err);
        check_word({name, " pslverr"}, 32'(err), 32'h0);
        check_word(name, data, exp);
    endtask

    task automatic write_operand(input logic [3:0] word, input logic [31:0] data);
        logic err;
        apb_write(word, data, err);
        check_word({word_name(word), " pslverr"}, 32'(err), 32'h0);
        exp_mem[word - 2] = data;
    endtask

    task automatic start_run(input logic sign);
        logic err;
        apb_write(reg_ctrl, {30'h0, sign, 1'b1}, err);
        check_word("ctrl pslverr", 32'(err), 32'h0);
    endtask

    // status polling that can also contend for the ram with iv reads
    task automatic wait_done(input logic contend);
        logic [31:0] status;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(reg_status, status, err);
        while (!status[1])
        begin
            if (contend)
                read_expect("iv", reg_iv, exp_mem[slot_iv]);
            polls++;
            if (polls > RUN_TIMEOUT)
                stop_with_error("timeout: run never reported done in status");
            apb_read(reg_status, status, err);
        end
    endtask

    task automatic check_all_words();
        for (int w = 2; w <= 9; w++)
            read_expect(word_name(w), 4'(w), exp_mem[w - 2]);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        read_expect("status", reg_status, 32'h1);
        check_all_words();
    endtask

    task automatic test_keygen();
        write_operand(reg_seed, 32'h1234_5678);
        write_operand(reg_iv, 32'h0BAD_F00D);
        start_run(1'b0);
        wait_done(1'b0);
        run_model(1'b0);
        // masking_rnd stays at its reset value
        check_all_words();
        read_expect("status", reg_status, 32'h3);
    endtask

    task automatic test_sign();
        write_operand(reg_iv, 32'hC0FF_EE11);
        write_operand(reg_privkey, 32'h5A5A_0F0F);
        write_operand(reg_hashed_msg, 32'h9E37_79B9);
        start_run(1'b1);
        wait_done(1'b0);
        run_model(1'b1);
        check_all_words();
    endtask

    task automatic test_errors();
        logic [31:0] data;
        logic        err;
        apb_write(reg_lambda, 32'hDEAD_BEEF, err);
        check_word("lambda write pslverr", 32'(err), 32'h1);
        read_expect("lambda", reg_lambda, exp_mem[slot_lambda]);
        apb_write(reg_status, 32'h0, err);
        check_word("status write pslverr", 32'(err), 32'h1);
        read_expect("status", reg_status, 32'h3);
        apb_write(4'd12, 32'h1, err);
        check_word("word 12 write pslverr", 32'(err), 32'h1);
        apb_read(4'd12, data, err);
        check_word("word 12 read pslverr", 32'(err), 32'h1);
        // same operands again so the results come out the same
        start_run(1'b1);
        apb_read(reg_status, data, err);
        check_word("status ready", 32'(data[0]), 32'h0);
        apb_write(reg_seed, 32'hFFFF_0000, err);
        check_word("busy seed write pslverr", 32'(err), 32'h1);
        wait_done(1'b0);
        check_all_words();
    endtask

    task automatic test_random();
        logic [31:0] mode;
        for (int run = 0; run < 10; run++)
        begin
            mode = $random(seed);
            write_operand(reg_seed, $random(seed));
            write_operand(reg_iv, $random(seed));
            write_operand(reg_privkey, $random(seed));
            write_operand(reg_hashed_msg, $random(seed));
            start_run(mode[0]);
            wait_done(1'b1);
            run_model(mode[0]);
            check_all_words();
        end
    endtask

    initial
    begin
        clk     = 1'b0;
        reset_n = 1'b0;
        apb_req = '0;
        seed    = 37;
        for (int i = 0; i < 8; i++)
            exp_mem[i] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        test_reset();
        test_keygen();
        test_sign();
        test_errors();
        test_random();
        $display("test passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
common/drbg_pkg.sv
design/operand_ram.sv
design/ram_arbiter.sv
design/apb_host_port.sv
drbg/drbg_core.sv
drbg/drbg_sequencer.sv
design/ecc_drbg_top.sv
verification/drbg_assertions.sv
verification/drbg_tb.sv
